// ==== src/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

    localparam int coord_w = 16;

    typedef logic signed [coord_w-1:0] coord_t;
    typedef logic [15:0] color_t;
    typedef logic [5:0] step_t;    // mesh step 0..47
    typedef logic [1:0] lane_t;    // 0 left, 1 middle, 2/3 right

    localparam step_t box_steps = 6'd30;
    localparam step_t mesh_steps = 6'd48;

    // lane edges in x
    localparam coord_t left_lane_left = -16'sd112;
    localparam coord_t left_lane_right = -16'sd80;
    localparam coord_t mid_lane_left = -16'sd16;
    localparam coord_t mid_lane_right = 16'sd16;
    localparam coord_t right_lane_left = 16'sd80;
    localparam coord_t right_lane_right = 16'sd112;

    localparam coord_t depth_close = 16'sd176;
    localparam coord_t depth_far = 16'sd208;
    localparam coord_t ground_y = 16'sd128;
    localparam coord_t lane_start_z = 16'sd64;
    localparam coord_t lane_end_z = 16'sd512;
    localparam coord_t line_width = 16'sd4;

    typedef enum logic [2:0] {
        FRONT,
        SIDE_LEFT,
        SIDE_RIGHT,
        TOP,
        BOTTOM,
        LANE_LINE
    } face_e;

    typedef enum logic {
        IDLE,
        ACTIVE
    } seq_state_e;

    function automatic color_t face_color(face_e face);
        case (face)
            FRONT:      face_color = 16'h0400;
            SIDE_LEFT:  face_color = 16'h0200;
            SIDE_RIGHT: face_color = 16'h0200; // same shade as the left side
            TOP:        face_color = 16'h1404;
            BOTTOM:     face_color = 16'h2204;
            LANE_LINE:  face_color = 16'h0000; // black lines
            default:    face_color = 16'h0000;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/vertex_step_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface vertex_step_if import sprite_pkg::*; ();

    step_t  step;
    logic   step_valid;
    logic   tri_start;   // first vertex of a triangle
    coord_t lane_left;
    coord_t lane_right;
    coord_t top_y;       // negated player height
    logic   ducking;

    modport seq (
        output step, step_valid, tri_start, lane_left, lane_right, top_y, ducking
    );

    modport sink (
        input step, step_valid, tri_start, lane_left, lane_right, top_y, ducking
    );

endinterface

`default_nettype wire

// ==== src/sprite_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_sequencer import sprite_pkg::*; (
    input wire clk,
    input wire rst,
    input wire activate,
    input wire coord_t player_height,
    input wire lane_t player_lane,
    input wire ducking,
    vertex_step_if.seq steps,
    output logic busy
);

    seq_state_e state;
    step_t step;
    logic [1:0] mod3;
    logic accept;
    coord_t lane_left;
    coord_t lane_right;
    coord_t top_y;
    logic duck_latched;

    assign accept = (state == IDLE) && activate;
    // also high on the accepting cycle so active lines up with edge A
    assign busy = accept || (state == ACTIVE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step <= '0;
            mod3 <= '0;
        end else if (accept) begin
            state <= ACTIVE;
            step <= '0;
            mod3 <= '0;
        end else if (state == ACTIVE) begin
            if (step == mesh_steps - 6'd1) begin
                state <= IDLE;
                step <= '0;
                mod3 <= '0;
            end else begin
                step <= step + 6'd1;
                mod3 <= (mod3 == 2'd2) ? 2'd0 : mod3 + 2'd1;
            end
        end
    end

    // run parameters, held for the whole mesh
    always_ff @(posedge clk) begin
        if (accept) begin
            case (player_lane)
                2'd0: begin
                    lane_left <= left_lane_left;
                    lane_right <= left_lane_right;
                end
                2'd1: begin
                    lane_left <= mid_lane_left;
                    lane_right <= mid_lane_right;
                end
                default: begin
                    lane_left <= right_lane_left;
                    lane_right <= right_lane_right;
                end
            endcase
            top_y <= -player_height;
            duck_latched <= ducking;
        end
    end

    assign steps.step = step;
    assign steps.step_valid = (state == ACTIVE);
    assign steps.tri_start = (mod3 == 2'd0);
    assign steps.lane_left = lane_left;
    assign steps.lane_right = lane_right;
    assign steps.top_y = top_y;
    assign steps.ducking = duck_latched;

endmodule

`default_nettype wire

// ==== src/player_box_geometry.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_box_geometry import sprite_pkg::*; #(
    parameter coord_t stand_height = 16'sd32,
    parameter coord_t duck_height = 16'sd16
) (
    vertex_step_if.sink steps,
    output coord_t box_x,
    output coord_t box_y,
    output coord_t box_z,
    output face_e box_face
);

    logic [2:0] corner; // {x right, y bottom, z far}
    coord_t bottom_y;

    assign bottom_y = steps.top_y - (steps.ducking ? duck_height : stand_height);

    always_comb begin
        case (steps.step)
            6'd0:  corner = 3'b000; // front
            6'd1:  corner = 3'b100;
            6'd2:  corner = 3'b010;
            6'd3:  corner = 3'b010;
            6'd4:  corner = 3'b100;
            6'd5:  corner = 3'b110;
            6'd6:  corner = 3'b000; // left side
            6'd7:  corner = 3'b010;
            6'd8:  corner = 3'b011;
            6'd9:  corner = 3'b011;
            6'd10: corner = 3'b001;
            6'd11: corner = 3'b000;
            6'd12: corner = 3'b100; // right side
            6'd13: corner = 3'b110;
            6'd14: corner = 3'b111;
            6'd15: corner = 3'b111;
            6'd16: corner = 3'b101;
            6'd17: corner = 3'b100;
            6'd18: corner = 3'b000; // top
            6'd19: corner = 3'b100;
            6'd20: corner = 3'b101;
            6'd21: corner = 3'b101;
            6'd22: corner = 3'b001;
            6'd23: corner = 3'b000;
            6'd24: corner = 3'b010; // bottom
            6'd25: corner = 3'b110;
            6'd26: corner = 3'b111;
            6'd27: corner = 3'b111;
            6'd28: corner = 3'b011;
            6'd29: corner = 3'b010;
            default: corner = 3'b000;
        endcase
    end

    assign box_x = corner[2] ? steps.lane_right : steps.lane_left;
    assign box_y = corner[1] ? bottom_y : steps.top_y;
    assign box_z = corner[0] ? depth_far : depth_close;

    always_comb begin
        if (steps.step < 6'd6) begin
            box_face = FRONT;
        end else if (steps.step < 6'd12) begin
            box_face = SIDE_LEFT;
        end else if (steps.step < 6'd18) begin
            box_face = SIDE_RIGHT;
        end else if (steps.step < 6'd24) begin
            box_face = TOP;
        end else begin
            box_face = BOTTOM;
        end
    end

endmodule

`default_nettype wire

// ==== src/lane_line_geometry.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_line_geometry import sprite_pkg::*; (
    vertex_step_if.sink steps,
    output coord_t line_x,
    output coord_t line_y,
    output coord_t line_z
);

    step_t rel;            // step within the lane part
    logic [2:0] edge_idx;
    logic [1:0] corner_idx;
    coord_t edge_x;
    coord_t inner_x;

    assign rel = steps.step - box_steps;
    assign edge_idx = 3'(rel / 6'd3);
    assign corner_idx = 2'(rel % 6'd3);

    always_comb begin
        case (edge_idx)
            3'd0: edge_x = left_lane_left;
            3'd1: edge_x = left_lane_right;
            3'd2: edge_x = mid_lane_left;
            3'd3: edge_x = mid_lane_right;
            3'd4: edge_x = right_lane_left;
            3'd5: edge_x = right_lane_right;
            default: edge_x = left_lane_left;
        endcase
    end

    // thin side grows into the lane
    assign inner_x = edge_idx[0] ? edge_x - line_width : edge_x + line_width;

    assign line_x = (corner_idx == 2'd1) ? inner_x : edge_x;
    assign line_y = ground_y;
    assign line_z = (corner_idx == 2'd2) ? lane_end_z : lane_start_z;

endmodule

`default_nettype wire

// ==== src/vertex_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_output_stage import sprite_pkg::*; #(
    parameter coord_t z_offset = 16'sd0
) (
    input wire clk,
    input wire rst,
    input wire busy,
    input wire coord_t box_x,
    input wire coord_t box_y,
    input wire coord_t box_z,
    input wire face_e box_face,
    input wire coord_t line_x,
    input wire coord_t line_y,
    input wire coord_t line_z,
    vertex_step_if.sink steps,
    output logic [3*coord_w-1:0] vertex,
    output color_t color,
    output logic new_triangle,
    output logic active
);

    logic in_box;
    coord_t sel_x;
    coord_t sel_y;
    coord_t sel_z;
    face_e face;

    assign in_box = steps.step < box_steps;
    assign sel_x = in_box ? box_x : line_x;
    assign sel_y = in_box ? box_y : line_y;
    assign sel_z = (in_box ? box_z : line_z) + z_offset;
    assign face = in_box ? box_face : LANE_LINE;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            new_triangle <= 1'b0;
        end else begin
            active <= busy;
            new_triangle <= steps.step_valid && steps.tri_start;
        end
    end

    // vertex and colour hold between runs
    always_ff @(posedge clk) begin
        if (steps.step_valid) begin
            vertex <= {sel_x, sel_y, sel_z};
            color <= face_color(face);
        end
    end

endmodule

`default_nettype wire

// ==== src/sprite_creator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_creator import sprite_pkg::*; #(
    parameter coord_t stand_height = 16'sd32,
    parameter coord_t duck_height = 16'sd16,
    parameter coord_t z_offset = 16'sd0
) (
    input wire clk,
    input wire rst,
    input wire coord_t player_height,
    input wire lane_t player_lane,
    input wire activate,       // one-cycle strobe
    input wire ducking,
    output logic [3*coord_w-1:0] vertex,
    output color_t color,
    output logic new_triangle,
    output logic active
);

    vertex_step_if steps_if ();

    logic busy;
    coord_t box_x;
    coord_t box_y;
    coord_t box_z;
    face_e box_face;
    coord_t line_x;
    coord_t line_y;
    coord_t line_z;

    sprite_sequencer seq0 (
        .clk(clk),
        .rst(rst),
        .activate(activate),
        .player_height(player_height),
        .player_lane(player_lane),
        .ducking(ducking),
        .steps(steps_if.seq),
        .busy(busy)
    );

    player_box_geometry #(
        .stand_height(stand_height),
        .duck_height(duck_height)
    ) box0 (
        .steps(steps_if.sink),
        .box_x(box_x),
        .box_y(box_y),
        .box_z(box_z),
        .box_face(box_face)
    );

    lane_line_geometry lines0 (
        .steps(steps_if.sink),
        .line_x(line_x),
        .line_y(line_y),
        .line_z(line_z)
    );

    vertex_output_stage #(
        .z_offset(z_offset)
    ) out0 (
        .clk(clk),
        .rst(rst),
        .busy(busy),
        .box_x(box_x),
        .box_y(box_y),
        .box_z(box_z),
        .box_face(box_face),
        .line_x(line_x),
        .line_y(line_y),
        .line_z(line_z),
        .steps(steps_if.sink),
        .vertex(vertex),
        .color(color),
        .new_triangle(new_triangle),
        .active(active)
    );

endmodule

`default_nettype wire

// ==== verification/sprite_creator_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_creator_asserts import sprite_pkg::*; (
    input wire clk,
    input wire rst,
    input wire seq_state_e state,
    input wire step_t step,
    input wire tri_start
);

    int fail_count = 0;
    logic running;

    assign running = (state == ACTIVE);

    step_in_range: assert property (@(posedge clk) disable iff (rst) step <= 6'd47)
        else begin
            fail_count++;
            $error("step went past the last vertex");
        end

    // every third step opens a triangle
    tri_start_on_mod3: assert property (@(posedge clk) disable iff (rst)
        tri_start == (step % 6'd3 == 6'd0))
        else begin
            fail_count++;
            $error("tri_start out of step with the mesh");
        end

    run_length: assert property (@(posedge clk) disable iff (rst)
        $rose(running) |-> ##48 !running)
        else begin
            fail_count++;
            $error("run did not return to idle after 48 vertices");
        end

    no_early_exit: assert property (@(posedge clk) disable iff (rst)
        running && step != 6'd47 |=> running)
        else begin
            fail_count++;
            $error("run left active before the last vertex");
        end

endmodule

bind sprite_sequencer sprite_creator_asserts asserts0 (
    .clk(clk),
    .rst(rst),
    .state(state),
    .step(step),
    .tri_start(steps.tri_start)
);

`default_nettype wire

// ==== verification/sprite_creator_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_creator_tb import sprite_pkg::*; ();

    localparam int rows = 6;

    logic clk;
    logic rst;
    logic activate;
    logic ducking;
    coord_t player_height;
    lane_t player_lane;
    logic [47:0] vertex;
    color_t color;
    logic new_triangle;
    logic active;

    // lane, height (0 takes one from the lcg), ducking, idle gap, disturb during run
    int row_lane [rows] = '{0, 1, 2, 3, 1, 0};
    int row_height [rows] = '{32, 40, 0, 0, 24, 0};
    int row_duck [rows] = '{0, 0, 0, 1, 1, 1};
    int row_gap [rows] = '{3, 1, 2, 4, 0, 2};
    int row_disturb [rows] = '{0, 0, 1, 1, 0, 0};

    sprite_creator dut0 (
        .clk(clk),
        .rst(rst),
        .player_height(player_height),
        .player_lane(player_lane),
        .activate(activate),
        .ducking(ducking),
        .vertex(vertex),
        .color(color),
        .new_triangle(new_triangle),
        .active(active)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // {colour, x, y, z} of mesh vertex k
    function automatic logic [63:0] expected_vertex(input int k, input int lane,
                                                    input int height, input bit duck);
        int xl;
        int top;
        int bottom;
        int x;
        int y;
        int z;
        int e;
        int c;
        int q;
        logic [11:0] quad;
        logic [11:0] order;
        logic [2:0] corner;
        logic [15:0] col;
        xl = (lane == 0) ? -112 : ((lane == 1) ? -16 : 80);
        top = -height;
        bottom = top - (duck ? 16 : 32);
        if (k < 30) begin
            // quad corners as a loop, octal digit {x right, y bottom, z far}
            case (k / 6)
                0: quad = 12'o0462;
                1: quad = 12'o0231;
                2: quad = 12'o4675;
                3: quad = 12'o0451;
                default: quad = 12'o2673;
            endcase
            case (k / 6)
                0: col = 16'h0400;
                1, 2: col = 16'h0200;
                3: col = 16'h1404;
                default: col = 16'h2204;
            endcase
            order = (k < 6) ? 12'b00_01_11_11_01_10 : 12'b00_01_10_10_11_00;
            q = int'(order[11 - 2 * (k % 6) -: 2]);
            corner = quad[11 - 3 * q -: 3];
            x = corner[2] ? xl + 32 : xl;
            y = corner[1] ? bottom : top;
            z = corner[0] ? 208 : 176;
        end else begin
            e = (k - 30) / 3;
            c = (k - 30) % 3;
            case (e)
                0: x = -112;
                1: x = -80;
                2: x = -16;
                3: x = 16;
                4: x = 80;
                default: x = 112;
            endcase
            if (c == 1) begin
                x = (e % 2 == 0) ? x + 4 : x - 4;  // toward the lane centre
            end
            y = 128;
            z = (c == 2) ? 512 : 64;
            col = 16'h0000;
        end
        return {col, 16'(x), 16'(y), 16'(z)};
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check(64'(active), 64'd0, "active while idle");
            check(64'(new_triangle), 64'd0, "new_triangle while idle");
        end
    endtask

    initial begin
        repeat (rows * 60 + 20) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", rows * 60 + 20);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int unsigned seed;
        int lane;
        int height;
        bit duck;
        seed = 68;
        rst <= 1'b1;
        activate <= 1'b0;
        ducking <= 1'b0;
        player_height <= '0;
        player_lane <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_idle(3);

        for (int r = 0; r < rows; r++) begin
            lane = row_lane[r];
            height = row_height[r];
            if (height == 0) begin
                seed = lcg_next(seed);
                height = 8 + int'((seed >> 16) % 32'd64);
            end
            duck = (row_duck[r] != 0);
            check_idle(row_gap[r]);
            @(posedge clk);
            activate <= 1'b1;
            player_lane <= 2'(lane);
            player_height <= 16'(height);
            ducking <= duck;
            @(posedge clk);   // accepting edge
            activate <= 1'b0;
            for (int t = 0; t < 50; t++) begin
                @(negedge clk);
                check(64'(active), 64'(t < 49), $sformatf("active, cycle %0d", t));
                check(64'(new_triangle), 64'(t >= 1 && t <= 48 && (t - 1) % 3 == 0),
                      $sformatf("new_triangle, cycle %0d", t));
                if (t >= 1 && t <= 48) begin
                    check({color, vertex}, expected_vertex(t - 1, lane, height, duck),
                          $sformatf("row %0d vertex %0d {color,x,y,z}", r, t - 1));
                end
                @(posedge clk);
                if (row_disturb[r] != 0 && t == 10) begin
                    // inputs move mid run, must not reach the mesh
                    activate <= 1'b1;
                    ducking <= !duck;
                    player_lane <= 2'(lane + 1);
                    player_height <= 16'(height + 5);
                end else begin
                    activate <= 1'b0;
                end
            end
        end
        check_idle(5);

        if (dut0.seq0.asserts0.fail_count != 0) begin
            $display("Sequencer assertions failed %0d times", dut0.seq0.asserts0.fail_count);
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
src/sprite_pkg.sv
src/vertex_step_if.sv
src/sprite_sequencer.sv
src/player_box_geometry.sv
src/lane_line_geometry.sv
src/vertex_output_stage.sv
src/sprite_creator.sv
verification/sprite_creator_asserts.sv
verification/sprite_creator_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module sprite_creator_tb -o sprite_creator_sim
	./obj_dir/sprite_creator_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
